//--- vendingMachine.f
design/vendPkg.sv
design/vendControl.sv
design/centsToDigits.sv
design/displayScan.sv
design/vendingMachine.sv
tb/vendingMachineTb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --timing --assert
LINT_FLAGS = --lint-only $(FLAGS)
SIM_FLAGS  = --binary $(FLAGS)
TOP        = vendingMachineTb
FILELIST   = vendingMachine.f
OBJ_DIR    = obj_dir
PASS_MSG   = Test completed successfully

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/vendingMachineTb.sv
`timescale 1ns/10ps
`default_nettype none

module vendingMachineTb
    import vendPkg::*;
();

    localparam int resetCycles     = 5;
    localparam int scanCycles      = 16;   // 4 digits x 2^2 cycles each
    localparam int pressNone       = 0;    // no strobe, just look
    localparam int pressCoin       = 1;
    localparam int pressItem       = 2;
    localparam int pressCancel     = 3;
    localparam int pressCancelCoin = 4;    // cancel and coin together

    logic                A1;
    logic                A2;
    logic [numSlots-1:0] itemPress;
    logic [numCoins-1:0] coinPress;
    logic                cancelPress;
    wire [numSlots-1:0]  ledGreen;
    wire [numSlots-1:0]  ledRed;
    wire [numSlots-1:0]  ledDispense;
    wire [3:0]           anode;
    wire [7:0]           segments;

    // scenario table, one entry per row in each queue
    string               rowName[$];
    int                  rowKind[$];
    int                  rowIdx[$];
    int                  rowAmount[$];
    bit                  rowNeg[$];
    logic [numSlots-1:0] rowDispense[$];

    bit tableLoaded = 1'b0;
    int modelCredit;       // credit tracked from the pricing rules
    int errorCount  = 0;
    int passCount   = 0;
    int failCount   = 0;

    vendingMachine #(.scanBits(2)) DUT (
        .A1(A1), .A2(A2),
        .itemPress(itemPress), .coinPress(coinPress), .cancelPress(cancelPress),
        .ledGreen(ledGreen), .ledRed(ledRed), .ledDispense(ledDispense),
        .anode(anode), .segments(segments)
    );

    initial begin
        A1 = 1'b0;
        forever #5 A1 = ~A1;   // 10 ns period
    end

    task automatic addRow(input string name, input int kind, input int idx,
                          input int amount, input bit negative,
                          input logic [numSlots-1:0] dispense);
        rowName.push_back(name);
        rowKind.push_back(kind);
        rowIdx.push_back(idx);
        rowAmount.push_back(amount);
        rowNeg.push_back(negative);
        rowDispense.push_back(dispense);
    endtask

    task automatic loadTable();
        //     name               kind             idx  amount neg dispense
        addRow("reset",           pressNone,       0,   0,     0,  9'b000000000);
        addRow("quarter",         pressCoin,       2,   25,    0,  9'b000000000);
        addRow("dollar",          pressCoin,       4,   125,   0,  9'b000000000);
        addRow("fifty",           pressCoin,       3,   175,   0,  9'b000000000);
        addRow("fiveRejected",    pressCoin,       5,   175,   0,  9'b000000000);
        addRow("cancelCredit",    pressCancel,     0,   0,     0,  9'b000000000);
        addRow("priceB1",         pressItem,       3,   175,   0,  9'b000000000);
        addRow("priceC3",         pressItem,       8,   375,   0,  9'b000000000);
        addRow("dollarAgain",     pressCoin,       4,   100,   0,  9'b000000000);
        addRow("shortC2",         pressItem,       7,   225,   1,  9'b000000000);
        addRow("fiftyAfterShort", pressCoin,       3,   150,   0,  9'b000000000);
        addRow("soldOutA2",       pressItem,       1,   150,   0,  9'b000000000);
        addRow("vendA3",          pressItem,       2,   25,    0,  9'b000000100);
        addRow("cancelAfterVend", pressCancel,     0,   0,     0,  9'b000000000);
        addRow("dollarExact",     pressCoin,       4,   100,   0,  9'b000000000);
        addRow("vendA1",          pressItem,       0,   0,     0,  9'b000000001);
        addRow("dime",            pressCoin,       1,   10,    0,  9'b000000000);
        addRow("cancelWithCoin",  pressCancelCoin, 2,   0,     0,  9'b000000000);
    endtask

    // one-cycle strobe, launched on a rising edge
    task automatic pulseStrobe(input int kind, input int idx);
        logic [numSlots-1:0] itemVec;
        logic [numCoins-1:0] coinVec;
        itemVec = '0;
        coinVec = '0;
        if (kind == pressItem) itemVec[idx] = 1'b1;
        if (kind == pressCoin || kind == pressCancelCoin) coinVec[idx] = 1'b1;
        @(posedge A1);
        itemPress   <= itemVec;
        coinPress   <= coinVec;
        cancelPress <= (kind == pressCancel || kind == pressCancelCoin);
        @(posedge A1);
        itemPress   <= '0;
        coinPress   <= '0;
        cancelPress <= 1'b0;
    endtask

    // credit after a press, straight from the pricing rules
    function automatic int nextCredit(input int credit, input int kind, input int idx);
        int price;
        int sum;
        if (kind == pressCancel || kind == pressCancelCoin) return 0;   // cancel wins
        if (kind == pressItem) begin
            price = int'(slotPrice[idx]);
            if (credit != 0 && price != 0 && credit >= price) return 0;   // sale
            return credit;   // price check, shortfall or sold out
        end
        if (kind == pressCoin) begin
            sum = credit + int'(coinValue[idx]);
            return (sum <= int'(maxCredit)) ? sum : credit;   // over the limit is refused
        end
        return credit;
    endfunction

    // pattern expected on a display position for a given amount
    function automatic logic [7:0] expectedPattern(input int pos, input int amount,
                                                   input bit negative);
        int         code;
        logic [7:0] pat;
        case (pos)
            0:       code = amount % 10;          // cents
            1:       code = (amount / 10) % 10;   // tens of cents
            2:       code = amount / 100;         // dollars
            default: code = negative ? 10 : 0;    // dash or leading zero
        endcase
        pat = segDigits[code];
        if (pos == dpDigit) pat[0] = 1'b0;        // point lit, active low
        return pat;
    endfunction

    task automatic checkRow(input int r);
        logic [7:0]          seen [4];
        bit                  lit  [4];
        logic [7:0]          expPat;
        logic [numSlots-1:0] expGreen;
        logic [numSlots-1:0] expRed;
        int                  rowErrors;
        int                  price;
        rowErrors = 0;
        for (int p = 0; p < 4; p++) begin
            seen[p] = '0;
            lit[p]  = 1'b0;
        end
        for (int c = 0; c < scanCycles; c++) begin
            @(negedge A1);   // outputs settled mid-cycle
            case (anode)
                4'b1110: begin
                    seen[0] = segments;
                    lit[0]  = 1'b1;
                end
                4'b1101: begin
                    seen[1] = segments;
                    lit[1]  = 1'b1;
                end
                4'b1011: begin
                    seen[2] = segments;
                    lit[2]  = 1'b1;
                end
                4'b0111: begin
                    seen[3] = segments;
                    lit[3]  = 1'b1;
                end
                default: begin
                    $display("%s: anode pattern %b drives no single digit", rowName[r], anode);
                    rowErrors++;
                end
            endcase
        end
        for (int p = 0; p < 4; p++) begin
            expPat = expectedPattern(p, rowAmount[r], rowNeg[r]);
            if (!lit[p]) begin
                $display("%s: digit%0d was never lit during a full scan", rowName[r], p);
                rowErrors++;
            end else begin
                assert (seen[p] === expPat) else begin
                    $display("FAILED %s digit%0d expected %b actual %b",
                             rowName[r], p, expPat, seen[p]);
                    rowErrors++;
                end
            end
        end
        for (int s = 0; s < numSlots; s++) begin
            price       = int'(slotPrice[s]);
            expGreen[s] = (modelCredit >= price) && (price != 0);
            expRed[s]   = (price == 0);
        end
        assert (ledGreen === expGreen) else begin
            $display("FAILED %s ledGreen expected %b actual %b", rowName[r], expGreen, ledGreen);
            rowErrors++;
        end
        assert (ledRed === expRed) else begin
            $display("FAILED %s ledRed expected %b actual %b", rowName[r], expRed, ledRed);
            rowErrors++;
        end
        assert (ledDispense === rowDispense[r]) else begin
            $display("FAILED %s ledDispense expected %b actual %b",
                     rowName[r], rowDispense[r], ledDispense);
            rowErrors++;
        end
        errorCount += rowErrors;
        if (rowErrors == 0) begin
            passCount++;
            $display("test %s ok", rowName[r]);
        end else begin
            failCount++;
            $display("test %s had %0d mismatches", rowName[r], rowErrors);
        end
    endtask

    initial begin
        int gap;
        A2          = 1'b1;   // reset held from time zero
        itemPress   = '0;
        coinPress   = '0;
        cancelPress = 1'b0;
        void'($urandom(68888));
        loadTable();
        tableLoaded = 1'b1;
        modelCredit = 0;
        repeat (resetCycles) @(posedge A1);
        A2 <= 1'b0;
        for (int r = 0; r < rowName.size(); r++) begin
            gap = $urandom_range(4, 1);   // idle cycles before the row
            repeat (gap) @(posedge A1);
            if (rowKind[r] != pressNone) begin
                pulseStrobe(rowKind[r], rowIdx[r]);
            end
            modelCredit = nextCredit(modelCredit, rowKind[r], rowIdx[r]);
            repeat (3) @(posedge A1);   // control then scan registers catch up
            checkRow(r);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 rowName.size(), passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // each row needs well under 30 cycles
    initial begin
        wait (tableLoaded);
        repeat (rowName.size() * 30 + resetCycles) @(posedge A1);
        $display("timeout: the scenario table did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/vendingMachine.sv
`timescale 1ns/10ps
`default_nettype none

module vendingMachine
    import vendPkg::*;
#(
    parameter int scanBits = defaultScanBits   // shrink for simulation
) (
    input  wire                 A1,            // clock
    input  wire                 A2,            // async reset, active high
    input  wire [numSlots-1:0]  itemPress,
    input  wire [numCoins-1:0]  coinPress,
    input  wire                 cancelPress,
    output logic [numSlots-1:0] ledGreen,
    output logic [numSlots-1:0] ledRed,
    output logic [numSlots-1:0] ledDispense,
    output logic [3:0]          anode,
    output logic [7:0]          segments
);

    cents_t dispCents;      // control to digit split
    logic   dispNegative;
    digit_t digit0;         // digit split to scan
    digit_t digit1;
    digit_t digit2;
    digit_t digit3;

    vendControl control (
        .A1(A1), .A2(A2),
        .itemPress(itemPress), .coinPress(coinPress), .cancelPress(cancelPress),
        .ledGreen(ledGreen), .ledRed(ledRed), .ledDispense(ledDispense),
        .dispCents(dispCents), .dispNegative(dispNegative)
    );

    centsToDigits digits (
        .dispCents(dispCents), .dispNegative(dispNegative),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3)
    );

    displayScan #(.scanBits(scanBits)) scan (
        .A1(A1), .A2(A2),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
        .anode(anode), .segments(segments)
    );

endmodule

`default_nettype wire

//--- design/displayScan.sv
`timescale 1ns/10ps
`default_nettype none

module displayScan
    import vendPkg::*;
#(
    parameter int scanBits = defaultScanBits   // log2 of cycles each digit stays lit
) (
    input  wire         A1,         // clock
    input  wire         A2,         // async reset, active high
    input  wire digit_t digit0,     // rightmost
    input  wire digit_t digit1,
    input  wire digit_t digit2,
    input  wire digit_t digit3,     // leftmost
    output logic [3:0]  anode,      // active low, one at a time
    output logic [7:0]  segments    // active low, bit 0 = decimal point
);

    digit_t              digitCode [4];
    logic [7:0]          digitSeg  [4];   // patterns for the four positions
    logic [scanBits+1:0] scanCount;       // top two bits pick the digit
    logic [1:0]          phase;

    always_comb begin
        digitCode[0] = digit0;
        digitCode[1] = digit1;
        digitCode[2] = digit2;
        digitCode[3] = digit3;
    end

    // pattern lookup, point forced on for the dollars digit
    always_ff @(posedge A1) begin
        for (int i = 0; i < 4; i++) begin
            digitSeg[i] <= segDigits[digitCode[i]] & ~{7'b0, (i == dpDigit)};
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCount <= '0;   // start on digit0
        end else begin
            scanCount <= scanCount + 1'b1;   // free running, wraps
        end
    end

    assign phase = scanCount[scanBits+1:scanBits];

    always_comb begin
        anode    = ~(4'b0001 << phase);   // 1110, 1101, 1011, 0111
        segments = digitSeg[phase];
    end

    // never two digits driven together, never a dark display
    anodeOneCold: assert property (@(posedge A1) disable iff (A2)
        $onehot(~anode))
        else $error("anode pattern %b not one-cold", anode);

endmodule

`default_nettype wire

//--- design/centsToDigits.sv
`timescale 1ns/10ps
`default_nettype none

module centsToDigits
    import vendPkg::*;
(
    input  wire cents_t dispCents,      // amount to split, 0..999
    input  wire         dispNegative,   // show a minus on the top digit
    output digit_t      digit0,         // cents
    output digit_t      digit1,         // tens of cents
    output digit_t      digit2,         // dollars
    output digit_t      digit3          // sign position
);

    cents_t dollars;
    cents_t dimes;
    cents_t pennies;

    // split the amount into its decimal places
    always_comb begin
        dollars = dispCents / 10'd100;
        dimes   = (dispCents / 10'd10) % 10'd10;
        pennies = dispCents % 10'd10;
    end

    assign digit0 = digit_t'(pennies);
    assign digit1 = digit_t'(dimes);
    assign digit2 = digit_t'(dollars);                       // below 10 while in range
    assign digit3 = dispNegative ? digitDash : digit_t'(0);  // leading zero otherwise

    // largest amount the control can produce is a 500 cent credit
    always_comb begin
        amountRange: assert (dispCents <= 10'd999)
            else $error("display amount %0d out of range", dispCents);
    end

endmodule

`default_nettype wire

//--- design/vendControl.sv
`timescale 1ns/10ps
`default_nettype none

module vendControl
    import vendPkg::*;
(
    input  wire                 A1,            // clock
    input  wire                 A2,            // async reset, active high
    input  wire [numSlots-1:0]  itemPress,     // one-cycle strobes, bit 0 = A1
    input  wire [numCoins-1:0]  coinPress,     // one-cycle strobes, bit 0 = nickel
    input  wire                 cancelPress,   // one-cycle strobe
    output logic [numSlots-1:0] ledGreen,      // credit covers the slot price
    output logic [numSlots-1:0] ledRed,        // slot sold out
    output logic [numSlots-1:0] ledDispense,   // slot just vended, one-hot
    output cents_t              dispCents,     // amount to show
    output logic                dispNegative   // amount is a shortfall
);

    cents_t                credit;     // money inserted so far
    logic [numSlots-1:0]   itemSel;    // lowest pressed slot, one-hot
    logic [numCoins-1:0]   coinSel;    // lowest pressed coin, one-hot
    logic                  itemHit;
    logic                  coinHit;
    cents_t                itemPrice;  // price of the selected slot
    cents_t                coinAmt;    // value of the selected coin
    logic [centsWidth:0]   coinSum;    // one spare bit so the limit test is exact
    logic                  coinOk;

    // isolate lowest set bit of each strobe vector
    assign itemSel = itemPress & (~itemPress + 1'b1);
    assign coinSel = coinPress & (~coinPress + 1'b1);
    assign itemHit = |itemPress;
    assign coinHit = |coinPress;

    always_comb begin
        itemPrice = '0;
        coinAmt   = '0;
        for (int i = 0; i < numSlots; i++) begin
            if (itemSel[i]) begin
                itemPrice = itemPrice | slotPrice[i];   // at most one term is live
            end
        end
        for (int i = 0; i < numCoins; i++) begin
            if (coinSel[i]) begin
                coinAmt = coinAmt | coinValue[i];
            end
        end
    end

    assign coinSum = {1'b0, credit} + {1'b0, coinAmt};
    assign coinOk  = (coinSum <= {1'b0, maxCredit});   // reject anything past the limit

    // panel LEDs follow the credit directly
    always_comb begin
        for (int i = 0; i < numSlots; i++) begin
            ledRed[i]   = (slotPrice[i] == '0);
            ledGreen[i] = (credit >= slotPrice[i]) && (slotPrice[i] != '0);
        end
    end

    // priority is cancel, then item, then coin
    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit       <= '0;
            dispCents    <= '0;
            dispNegative <= 1'b0;
            ledDispense  <= '0;
        end else if (cancelPress) begin
            credit       <= '0;   // drop everything
            dispCents    <= '0;
            dispNegative <= 1'b0;
            ledDispense  <= '0;
        end else if (itemHit) begin
            if (credit == '0) begin
                dispCents    <= itemPrice;   // price check only
                dispNegative <= 1'b0;
            end else if (itemPrice != '0) begin   // sold-out press with credit is ignored
                if (credit >= itemPrice) begin
                    dispCents    <= credit - itemPrice;   // change due
                    dispNegative <= 1'b0;
                    ledDispense  <= itemSel;
                    credit       <= '0;                   // sale closes the transaction
                end else begin
                    dispCents    <= itemPrice - credit;   // still owed, credit kept
                    dispNegative <= 1'b1;
                end
            end
        end else if (coinHit && coinOk) begin
            credit       <= coinSum[centsWidth-1:0];
            dispCents    <= coinSum[centsWidth-1:0];   // show running credit
            dispNegative <= 1'b0;
            ledDispense  <= '0;                        // new transaction started
        end
    end

    creditLimit: assert property (@(posedge A1) disable iff (A2)
        credit <= maxCredit)
        else $error("credit %0d above limit", credit);

    // vend marks exactly one slot, a later coin or cancel clears it
    dispenseOneHot: assert property (@(posedge A1) disable iff (A2)
        $onehot0(ledDispense))
        else $error("dispense LEDs not one-hot: %b", ledDispense);

endmodule

`default_nettype wire

//--- design/vendPkg.sv
`default_nettype none

package vendPkg;

    localparam int numSlots   = 9;    // 3x3 panel, slot 0 = A1 ... slot 8 = C3
    localparam int numCoins   = 6;    // nickel, dime, quarter, fifty, dollar, five
    localparam int centsWidth = 10;   // covers the 0..999 display range

    typedef logic [centsWidth-1:0] cents_t;   // money amount in cents
    typedef logic [3:0]            digit_t;   // 0-9 numeral, 10 dash

    // zero price marks a sold-out slot
    localparam cents_t slotPrice [numSlots] = '{
        10'd100,   // A1
        10'd0,     // A2, sold out
        10'd125,   // A3
        10'd175,   // B1
        10'd225,   // B2
        10'd250,   // B3
        10'd100,   // C1
        10'd325,   // C2
        10'd375    // C3
    };

    localparam cents_t coinValue [numCoins] = '{
        10'd5, 10'd10, 10'd25, 10'd50, 10'd100, 10'd500
    };

    localparam cents_t maxCredit = 10'd500;   // inserts past this are rejected

    localparam digit_t digitDash = 4'd10;   // code for the minus sign

    // active low, bit 0 is the decimal point
    localparam logic [7:0] segDigits [11] = '{
        8'b10000001, 8'b11110011, 8'b01001001, 8'b01100001,   // 0-3
        8'b00110011, 8'b00100101, 8'b00000101, 8'b11110001,   // 4-7
        8'b00000001, 8'b00100001,                             // 8-9
        8'b01111111                                           // dash
    };

    localparam int dpDigit         = 2;    // dollars digit carries the point
    localparam int defaultScanBits = 17;   // per-digit hold on the board clock

endpackage

`default_nettype wire
